// ==== hw/tpu_ctrl_pkg.sv ====
`default_nettype none

package tpu_ctrl_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int INSTR_W   = 32;                         // Instruction word
    localparam int PC_W      = 8;                          // Program counter
    localparam int ARG_W     = 8;                          // Each argument field
    localparam int FLAG_W    = 2;
    localparam int OPCODE_W  = INSTR_W - 3 * ARG_W - FLAG_W; // Top 6 bits
    localparam int UB_ADDR_W = ARG_W + 1;                  // Bank bit on top of 8
    localparam int LEN_W     = 2 * ARG_W;                  // arg2:arg3 pairs
    localparam int CFG_DEPTH = 16;
    localparam int CFG_AW    = $clog2(CFG_DEPTH);
    localparam int CFG_DW    = 2 * ARG_W;
    localparam int UNIT_CNT  = 4;                          // Units under the SYNC mask

    // Mask bit positions
    localparam int UNIT_SYS  = 0;
    localparam int UNIT_VPU  = 1;
    localparam int UNIT_DMA  = 2;
    localparam int UNIT_WT   = 3;

    // ==============================
    // Opcodes and modes
    // ==============================
    // Only the kept part of the ISA, everything else decodes as NOP
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP         = 6'h00,
        OP_RD_HOST_MEM = 6'h01,   // Host to UB
        OP_WR_HOST_MEM = 6'h02,   // UB to host
        OP_MATMUL      = 6'h10,
        OP_MATMUL_ACC  = 6'h12,
        OP_RELU        = 6'h18,
        OP_SIGMOID     = 6'h1A,
        OP_SYNC        = 6'h30,   // Bank swap plus wait
        OP_CFG_REG     = 6'h31,
        OP_HALT        = 6'h3F
    } opcode_e;

    typedef enum logic [1:0] {
        SYS_MATMUL = 2'd0,
        SYS_ACCUM  = 2'd2         // Add into existing partial sums
    } sys_mode_e;

    typedef enum logic [3:0] {
        VPU_OFF     = 4'd0,
        VPU_RELU    = 4'd1,
        VPU_SIGMOID = 4'd3
    } vpu_mode_e;

    typedef enum logic {
        SYNC_IDLE = 1'b0,
        SYNC_WAIT = 1'b1
    } sync_state_e;

    // ==============================
    // Instruction and pipeline records
    // ==============================
    // Raw word as read from instruction memory, opcode may be any value
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;   // [31:26]
        logic [ARG_W-1:0]    arg1;     // [25:18]
        logic [ARG_W-1:0]    arg2;     // [17:10]
        logic [ARG_W-1:0]    arg3;     // [9:2]
        logic [FLAG_W-1:0]   flags;    // [1:0]
    } instr_t;

    typedef struct packed {
        logic                valid;
        opcode_e             opcode;   // Kept opcodes only
        logic [ARG_W-1:0]    arg1;
        logic [ARG_W-1:0]    arg2;
        logic [ARG_W-1:0]    arg3;
        logic [FLAG_W-1:0]   flags;
        logic                bank;     // Parity seen at decode
    } decoded_t;

    // ==============================
    // Datapath control bundles
    // ==============================
    typedef struct packed {
        logic                start;
        sys_mode_e           mode;
        logic [ARG_W-1:0]    rows;
        logic                is_signed;
        logic                transpose;
        logic [ARG_W-1:0]    acc_addr;
        logic                acc_clear;
    } sys_ctrl_t;

    typedef struct packed {
        logic                 rd_en;
        logic                 wr_en;
        logic [UB_ADDR_W-1:0] rd_addr;   // {bank, addr}
        logic [UB_ADDR_W-1:0] wr_addr;
        logic [UB_ADDR_W-1:0] rd_count;
        logic [UB_ADDR_W-1:0] wr_count;
        logic                 bank;
    } ub_ctrl_t;

    typedef struct packed {
        logic             wr_en;
        logic             rd_en;
        logic [ARG_W-1:0] addr;
        logic             bank;
    } acc_ctrl_t;

    typedef struct packed {
        logic              start;
        vpu_mode_e         mode;
        logic [ARG_W-1:0]  in_addr;
        logic [ARG_W-1:0]  out_addr;
        logic [ARG_W-1:0]  length;
        logic [CFG_DW-1:0] param;     // From config file or 0
    } vpu_ctrl_t;

    typedef struct packed {
        logic              start;
        logic              dir;       // 0 host to UB, 1 UB to host
        logic [ARG_W-1:0]  ub_addr;
        logic [LEN_W-1:0]  length;
        logic [FLAG_W-1:0] elem_sz;
    } dma_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/tpu_fetch_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_fetch_decode (
    input  wire                          clk,
    input  wire                          rst_n,
    output logic [tpu_ctrl_pkg::PC_W-1:0] instr_addr,
    input  wire  tpu_ctrl_pkg::instr_t   instr_data,
    input  wire                          stall,
    input  wire                          halted,
    input  wire                          bank,
    output tpu_ctrl_pkg::decoded_t       dec
);
    import tpu_ctrl_pkg::*;

    logic [PC_W-1:0] pc;
    instr_t          ir;
    logic            ir_valid;     // IR holds a fetched word
    opcode_e         dec_op;
    decoded_t        dec_next;
    decoded_t        dec_q;

    // ==============================
    // Fetch
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            ir       <= '0;
            ir_valid <= 1'b0;
        end else if (halted) begin
            ir_valid <= 1'b0;          // Fetch is dead from here on
        end else if (!stall) begin
            pc       <= pc + PC_W'(1);
            ir       <= instr_data;
            ir_valid <= 1'b1;
        end
    end

    assign instr_addr = pc;

    // ==============================
    // Decode
    // ==============================
    // Dropped or unknown opcodes fall through to NOP
    always_comb begin
        case (ir.opcode)
            OP_NOP,
            OP_RD_HOST_MEM,
            OP_WR_HOST_MEM,
            OP_MATMUL,
            OP_MATMUL_ACC,
            OP_RELU,
            OP_SIGMOID,
            OP_SYNC,
            OP_CFG_REG,
            OP_HALT: dec_op = opcode_e'(ir.opcode);
            default: dec_op = OP_NOP;
        endcase
    end

    always_comb begin
        dec_next.valid  = ir_valid;
        dec_next.opcode = dec_op;
        dec_next.arg1   = ir.arg1;
        dec_next.arg2   = ir.arg2;
        dec_next.arg3   = ir.arg3;
        dec_next.flags  = ir.flags;
        dec_next.bank   = bank;        // Parity as of this decode
    end

    // Decode register, held under stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_q <= '0;
        end else if (halted) begin
            dec_q.valid <= 1'b0;       // Drop whatever follows HALT
        end else if (!stall) begin
            dec_q <= dec_next;
        end
    end

    assign dec = dec_q;

endmodule

`default_nettype wire

// ==== hw/tpu_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_execute (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  tpu_ctrl_pkg::decoded_t       dec,
    input  wire                                stall,
    input  wire  [tpu_ctrl_pkg::CFG_DW-1:0]    cfg_rdata,
    output tpu_ctrl_pkg::decoded_t             issued,
    output logic [tpu_ctrl_pkg::CFG_AW-1:0]    cfg_raddr,
    output tpu_ctrl_pkg::sys_ctrl_t            sys_ctrl,
    output tpu_ctrl_pkg::ub_ctrl_t             ub_ctrl,
    output tpu_ctrl_pkg::acc_ctrl_t            acc_ctrl,
    output tpu_ctrl_pkg::vpu_ctrl_t            vpu_ctrl,
    output tpu_ctrl_pkg::dma_ctrl_t            dma_ctrl
);
    import tpu_ctrl_pkg::*;

    decoded_t ex_q;
    logic     ex_halt;       // HALT sits in execute right now

    assign ex_halt = ex_q.valid && (ex_q.opcode == OP_HALT);

    // ==============================
    // Execute register
    // ==============================
    // Stall or HALT turns the load into a bubble, payload still follows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q       <= dec;
            ex_q.valid <= dec.valid && !stall && !ex_halt;
        end
    end

    assign issued    = ex_q;
    assign cfg_raddr = CFG_AW'(ex_q.flags);   // Activation param index

    // ==============================
    // Control generation
    // ==============================
    always_comb begin
        // Everything idle, banks track the executing record
        sys_ctrl      = '0;
        ub_ctrl       = '0;
        ub_ctrl.bank  = ex_q.bank;
        acc_ctrl      = '0;
        acc_ctrl.bank = ex_q.bank;
        vpu_ctrl      = '0;
        dma_ctrl      = '0;

        if (ex_q.valid) begin
            case (ex_q.opcode)
                OP_RD_HOST_MEM,
                OP_WR_HOST_MEM: begin
                    dma_ctrl.start   = 1'b1;
                    dma_ctrl.dir     = (ex_q.opcode == OP_WR_HOST_MEM);
                    dma_ctrl.ub_addr = ex_q.arg1;
                    dma_ctrl.length  = {ex_q.arg2, ex_q.arg3};
                    dma_ctrl.elem_sz = ex_q.flags;
                end

                OP_MATMUL,
                OP_MATMUL_ACC: begin
                    sys_ctrl.start     = 1'b1;
                    sys_ctrl.mode      = (ex_q.opcode == OP_MATMUL) ? SYS_MATMUL : SYS_ACCUM;
                    sys_ctrl.rows      = ex_q.arg3;
                    sys_ctrl.is_signed = ex_q.flags[1];
                    sys_ctrl.transpose = ex_q.flags[0];
                    sys_ctrl.acc_addr  = ex_q.arg2;
                    sys_ctrl.acc_clear = (ex_q.opcode == OP_MATMUL);  // ACC keeps sums
                    // Activations in from the live bank
                    ub_ctrl.rd_en      = 1'b1;
                    ub_ctrl.rd_addr    = {ex_q.bank, ex_q.arg1};
                    ub_ctrl.rd_count   = UB_ADDR_W'(1);
                    acc_ctrl.wr_en     = 1'b1;
                    acc_ctrl.addr      = ex_q.arg2;
                end

                OP_RELU,
                OP_SIGMOID: begin
                    vpu_ctrl.start    = 1'b1;
                    vpu_ctrl.mode     = (ex_q.opcode == OP_RELU) ? VPU_RELU : VPU_SIGMOID;
                    vpu_ctrl.in_addr  = ex_q.arg1;
                    vpu_ctrl.out_addr = ex_q.arg2;
                    vpu_ctrl.length   = ex_q.arg3;
                    vpu_ctrl.param    = ex_q.flags[0] ? cfg_rdata : '0;
                    // Results of the previous phase sit in the other bank
                    acc_ctrl.rd_en    = 1'b1;
                    acc_ctrl.addr     = ex_q.arg1;
                    acc_ctrl.bank     = ~ex_q.bank;
                    ub_ctrl.wr_en     = 1'b1;
                    ub_ctrl.wr_addr   = {~ex_q.bank, ex_q.arg2};
                    ub_ctrl.wr_count  = UB_ADDR_W'(1);
                end

                // SYNC, CFG_REG and HALT act through the issued record
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/tpu_sync_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_sync_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  tpu_ctrl_pkg::decoded_t issued,
    input  wire                          sys_busy,
    input  wire                          vpu_busy,
    input  wire                          dma_busy,
    input  wire                          wt_busy,
    output logic                         stall,
    output logic                         bank,
    output logic                         halted,
    output logic                         halt_req,
    output logic                         interrupt_en,
    output logic                         pipeline_stall
);
    import tpu_ctrl_pkg::*;

    sync_state_e         state;
    logic [LEN_W-1:0]    wait_cnt;
    logic [LEN_W-1:0]    timeout_q;
    logic [UNIT_CNT-1:0] mask_q;
    logic [UNIT_CNT-1:0] busy_vec;
    logic                bank_q;
    logic                halt_q;
    logic                sync_issue;
    logic                halt_issue;
    logic                wait_done;

    assign sync_issue = issued.valid && (issued.opcode == OP_SYNC);
    assign halt_issue = issued.valid && (issued.opcode == OP_HALT);

    always_comb begin
        busy_vec           = '0;
        busy_vec[UNIT_SYS] = sys_busy;
        busy_vec[UNIT_VPU] = vpu_busy;
        busy_vec[UNIT_DMA] = dma_busy;
        busy_vec[UNIT_WT]  = wt_busy;
    end

    // Masked units idle, or timeout reached
    assign wait_done = ~|(busy_vec & mask_q) || (wait_cnt >= timeout_q);

    // ==============================
    // SYNC FSM and parity
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SYNC_IDLE;
            wait_cnt  <= '0;
            timeout_q <= '0;
            mask_q    <= '0;
            bank_q    <= 1'b0;
        end else if (sync_issue) begin
            state     <= SYNC_WAIT;
            wait_cnt  <= '0;
            timeout_q <= {issued.arg2, issued.arg3};
            mask_q    <= issued.arg1[UNIT_CNT-1:0];
            bank_q    <= ~bank_q;                  // Swap double buffers
        end else if (state == SYNC_WAIT) begin
            if (wait_done) state <= SYNC_IDLE;
            else           wait_cnt <= wait_cnt + LEN_W'(1);
        end
    end

    // Halt is sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)          halt_q <= 1'b0;
        else if (halt_issue) halt_q <= 1'b1;
    end

    assign stall          = |busy_vec || (state == SYNC_WAIT);
    assign pipeline_stall = stall;
    assign bank           = bank_q;
    assign halted         = halt_q || halt_issue;   // Kills fetch on the HALT edge
    assign halt_req       = halted;
    assign interrupt_en   = halt_issue;             // One cycle pulse

endmodule

`default_nettype wire

// ==== hw/tpu_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_cfg_regs (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  tpu_ctrl_pkg::decoded_t     issued,
    input  wire  [tpu_ctrl_pkg::CFG_AW-1:0]  raddr,
    output logic [tpu_ctrl_pkg::CFG_DW-1:0]  rdata
);
    import tpu_ctrl_pkg::*;

    logic [CFG_DW-1:0] cfg_mem [CFG_DEPTH];
    logic              cfg_we;

    assign cfg_we = issued.valid && (issued.opcode == OP_CFG_REG);

    // Entry arg1[3:0] takes arg2:arg3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CFG_DEPTH; i++) begin
                cfg_mem[i] <= '0;
            end
        end else if (cfg_we) begin
            cfg_mem[issued.arg1[CFG_AW-1:0]] <= {issued.arg2, issued.arg3};
        end
    end

    assign rdata = cfg_mem[raddr];   // Async read for the VPU param

endmodule

`default_nettype wire

// ==== hw/tpu_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_controller (
    input  wire                           clk,
    input  wire                           rst_n,
    // Instruction memory
    output logic [tpu_ctrl_pkg::PC_W-1:0] instr_addr,
    input  wire  tpu_ctrl_pkg::instr_t    instr_data,
    // Unit status levels
    input  wire                           sys_busy,
    input  wire                           vpu_busy,
    input  wire                           dma_busy,
    input  wire                           wt_busy,
    // Datapath control
    output tpu_ctrl_pkg::sys_ctrl_t       sys_ctrl,
    output tpu_ctrl_pkg::ub_ctrl_t        ub_ctrl,
    output tpu_ctrl_pkg::acc_ctrl_t       acc_ctrl,
    output tpu_ctrl_pkg::vpu_ctrl_t       vpu_ctrl,
    output tpu_ctrl_pkg::dma_ctrl_t       dma_ctrl,
    // Program status
    output logic                          halt_req,
    output logic                          interrupt_en,
    output logic                          pipeline_stall
);
    import tpu_ctrl_pkg::*;

    decoded_t          dec;
    decoded_t          issued;
    logic              stall;
    logic              bank;
    logic              halted;
    logic [CFG_AW-1:0] cfg_raddr;
    logic [CFG_DW-1:0] cfg_rdata;

    // ==============================
    // Pipeline stages
    // ==============================
    tpu_fetch_decode u_fetch_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .stall      (stall),
        .halted     (halted),
        .bank       (bank),
        .dec        (dec)
    );

    tpu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .stall     (stall),
        .cfg_rdata (cfg_rdata),
        .issued    (issued),
        .cfg_raddr (cfg_raddr),
        .sys_ctrl  (sys_ctrl),
        .ub_ctrl   (ub_ctrl),
        .acc_ctrl  (acc_ctrl),
        .vpu_ctrl  (vpu_ctrl),
        .dma_ctrl  (dma_ctrl)
    );

    // ==============================
    // Side effects of issued records
    // ==============================
    tpu_sync_unit u_sync_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .issued         (issued),
        .sys_busy       (sys_busy),
        .vpu_busy       (vpu_busy),
        .dma_busy       (dma_busy),
        .wt_busy        (wt_busy),
        .stall          (stall),
        .bank           (bank),
        .halted         (halted),
        .halt_req       (halt_req),
        .interrupt_en   (interrupt_en),
        .pipeline_stall (pipeline_stall)
    );

    tpu_cfg_regs u_cfg_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .issued (issued),
        .raddr  (cfg_raddr),
        .rdata  (cfg_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/tpu_controller_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_controller_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire tpu_ctrl_pkg::sys_ctrl_t sys_ctrl,
    input wire tpu_ctrl_pkg::vpu_ctrl_t vpu_ctrl,
    input wire tpu_ctrl_pkg::dma_ctrl_t dma_ctrl,
    input wire                          halt_req,
    input wire                          interrupt_en,
    input wire                          pipeline_stall
);
    import tpu_ctrl_pkg::*;

    logic [2:0] starts;

    assign starts = {sys_ctrl.start, vpu_ctrl.start, dma_ctrl.start};

    // One instruction per cycle, so one unit start
    a_one_start: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(starts))
        else $error("More than one unit start in a cycle");

    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        pipeline_stall |=> (starts == 3'b000))
        else $error("Start issued right after a stall cycle");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt_req |=> halt_req)
        else $error("halt_req fell before reset");

    a_irq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        interrupt_en |=> !interrupt_en)
        else $error("interrupt_en longer than one cycle");

endmodule

bind tpu_controller tpu_controller_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .sys_ctrl       (sys_ctrl),
    .vpu_ctrl       (vpu_ctrl),
    .dma_ctrl       (dma_ctrl),
    .halt_req       (halt_req),
    .interrupt_en   (interrupt_en),
    .pipeline_stall (pipeline_stall)
);

`default_nettype wire

// ==== dv/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each row holds the instruction word, an issue flag (1 if the entry drives a start or enable)
// and the expected bundle with bank bits at 0 (parity is added per entry by rule)
task automatic load_program();
    prog_len = 0;
    // Host traffic and matmuls under random busy pulses
    add_row(enc(OP_RD_HOST_MEM, 8'h10, 8'h01, 8'h20, 2'd1), 1'b1,
            dma_b(1'b0, 8'h10, 16'h0120, 2'd1));
    add_row(enc(OP_MATMUL, 8'h10, 8'h40, 8'h08, 2'b10), 1'b1,
            mm_b(SYS_MATMUL, 8'h08, 1'b1, 1'b0, 8'h40, 1'b1, 8'h10));
    add_row(enc(OP_MATMUL_ACC, 8'h11, 8'h40, 8'h10, 2'b01), 1'b1,
            mm_b(SYS_ACCUM, 8'h10, 1'b0, 1'b1, 8'h40, 1'b0, 8'h11));
    add_row(enc(OP_WR_HOST_MEM, 8'h30, 8'h00, 8'h80, 2'd2), 1'b1,
            dma_b(1'b1, 8'h30, 16'h0080, 2'd2));
    // Config entries 1 and 0 then activations
    add_row(enc(OP_CFG_REG, 8'h01, 8'hBE, 8'hEF, 2'd0), 1'b0, '0);
    add_row(enc(OP_CFG_REG, 8'hF0, 8'h12, 8'h34, 2'd0), 1'b0, '0);   // Lands in entry 0
    add_row(enc(OP_RELU, 8'h40, 8'h50, 8'h08, 2'd1), 1'b1,
            act_b(VPU_RELU, 8'h40, 8'h50, 8'h08, 16'hBEEF));
    add_row(enc(OP_SIGMOID, 8'h41, 8'h51, 8'h04, 2'd0), 1'b1,
            act_b(VPU_SIGMOID, 8'h41, 8'h51, 8'h04, 16'h0000));
    // SYNC on systolic with a long timeout
    add_row(enc(OP_SYNC, 8'h01, 8'h01, 8'h00, 2'd0), 1'b0, '0);
    add_row(enc(OP_NOP, 8'h00, 8'h00, 8'h00, 2'd0), 1'b0, '0);
    add_row(enc(6'h20, 8'h12, 8'h34, 8'h56, 2'd3), 1'b0, '0);   // Dropped opcode
    add_row(enc(OP_MATMUL, 8'h22, 8'h60, 8'h04, 2'b11), 1'b1,
            mm_b(SYS_MATMUL, 8'h04, 1'b1, 1'b1, 8'h60, 1'b1, 8'h22));
    // SYNC on vector unit with timeout 4
    add_row(enc(OP_SYNC, 8'h02, 8'h00, 8'h04, 2'd0), 1'b0, '0);
    add_row(enc(OP_NOP, 8'h00, 8'h00, 8'h00, 2'd0), 1'b0, '0);
    add_row(enc(OP_NOP, 8'h00, 8'h00, 8'h00, 2'd0), 1'b0, '0);
    add_row(enc(OP_RELU, 8'h60, 8'h70, 8'h10, 2'd2), 1'b1,
            act_b(VPU_RELU, 8'h60, 8'h70, 8'h10, 16'h0000));
    add_row(enc(OP_HALT, 8'h00, 8'h00, 8'h00, 2'd0), 1'b0, '0);
    add_row(enc(OP_MATMUL, 8'h01, 8'h02, 8'h03, 2'd0), 1'b0, '0);   // Past HALT
endtask

`endif

// ==== dv/tb_tpu_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tpu_controller;
    import tpu_ctrl_pkg::*;

    typedef struct packed {
        sys_ctrl_t sys;
        ub_ctrl_t  ub;
        acc_ctrl_t acc;
        vpu_ctrl_t vpu;
        dma_ctrl_t dma;
    } bundle_t;

    localparam int CW        = $bits(bundle_t);
    localparam int MEM_DEPTH = 256;
    localparam int TBL_MAX   = 32;

    logic            clk;
    logic            rst_n;
    logic [PC_W-1:0] instr_addr;
    instr_t          instr_data;
    logic            sys_busy;
    logic            vpu_busy;
    logic            dma_busy;
    logic            wt_busy;
    sys_ctrl_t       sys_ctrl;
    ub_ctrl_t        ub_ctrl;
    acc_ctrl_t       acc_ctrl;
    vpu_ctrl_t       vpu_ctrl;
    dma_ctrl_t       dma_ctrl;
    logic            halt_req;
    logic            interrupt_en;
    logic            pipeline_stall;

    instr_t      imem [MEM_DEPTH];
    instr_t      prog_word [TBL_MAX];
    bundle_t     prog_exp [TBL_MAX];
    logic        prog_issues [TBL_MAX];
    int          prog_len;
    bundle_t     seen_q [$];                // Issued bundles in order
    logic [31:0] lcg_state = 32'hefd96274;
    int          fail_cnt = 0;

    tpu_controller uut (.*);

    assign instr_data = imem[instr_addr];  // Combinational instruction memory

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instr_t enc(logic [5:0] op, logic [7:0] a1, logic [7:0] a2,
                                   logic [7:0] a3, logic [1:0] fl);
        return {op, a1, a2, a3, fl};
    endfunction

    function automatic bundle_t dma_b(logic dir, logic [7:0] addr, logic [15:0] len,
                                      logic [1:0] esz);
        bundle_t b = '0;
        b.dma = '{start: 1'b1, dir: dir, ub_addr: addr, length: len, elem_sz: esz};
        return b;
    endfunction

    function automatic bundle_t mm_b(sys_mode_e mode, logic [7:0] rows, logic sgn,
                                     logic tr, logic [7:0] acc, logic clr, logic [7:0] ub);
        bundle_t b = '0;
        b.sys = '{start: 1'b1, mode: mode, rows: rows, is_signed: sgn, transpose: tr,
                  acc_addr: acc, acc_clear: clr};
        b.ub.rd_en    = 1'b1;
        b.ub.rd_addr  = {1'b0, ub};
        b.ub.rd_count = 9'd1;
        b.acc.wr_en   = 1'b1;
        b.acc.addr    = acc;
        return b;
    endfunction

    function automatic bundle_t act_b(vpu_mode_e mode, logic [7:0] in_a, logic [7:0] out_a,
                                      logic [7:0] len, logic [15:0] param);
        bundle_t b = '0;
        b.vpu = '{start: 1'b1, mode: mode, in_addr: in_a, out_addr: out_a, length: len,
                  param: param};
        b.acc.rd_en   = 1'b1;
        b.acc.addr    = in_a;
        b.ub.wr_en    = 1'b1;
        b.ub.wr_addr  = {1'b0, out_a};
        b.ub.wr_count = 9'd1;
        return b;
    endfunction

    task automatic add_row(instr_t w, logic issues, bundle_t exp);
        prog_word[prog_len]   = w;
        prog_issues[prog_len] = issues;
        prog_exp[prog_len]    = exp;
        prog_len++;
    endtask

    `include "tb_program.svh"

    // SYNCs three or more slots back have flipped the bank
    function automatic logic parity_at(int idx);
        int syncs;
        syncs = 0;
        for (int j = 0; j <= idx - 3; j++) begin
            if (prog_word[j].opcode == OP_SYNC) syncs++;
        end
        return syncs[0];
    endfunction

    // Reads from the live bank, writes results to the other one
    function automatic bundle_t with_parity(bundle_t b, logic p);
        b.ub.bank  = p;
        b.acc.bank = p;
        if (b.ub.rd_en) b.ub.rd_addr[UB_ADDR_W-1] = p;
        if (b.ub.wr_en) b.ub.wr_addr[UB_ADDR_W-1] = ~p;
        if (b.acc.rd_en) b.acc.bank = ~p;
        return b;
    endfunction

    function automatic bundle_t bundle_now();
        return {sys_ctrl, ub_ctrl, acc_ctrl, vpu_ctrl, dma_ctrl};
    endfunction

    task automatic fail_run(string msg);
        fail_cnt++;
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check(string what, logic [CW-1:0] got, logic [CW-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s: got %0h expected %0h",
                               $time, what, got, exp));
    endtask

    // ==============================
    // Monitor
    // ==============================
    always @(negedge clk) begin
        if (rst_n && (sys_ctrl.start || ub_ctrl.rd_en || ub_ctrl.wr_en || acc_ctrl.wr_en ||
                      acc_ctrl.rd_en || vpu_ctrl.start || dma_ctrl.start))
            seen_q.push_back(bundle_now());
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic random_busy_until_wr();
        int cycles;
        int left;
        logic [3:0] pick;
        logic seen;
        cycles = 0;
        left   = 0;
        pick   = 4'b0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #5;
            if (left == 0) begin
                pick = 4'(lcg_next() >> 8);          // Zero means an idle gap
                left = 1 + int'((lcg_next() >> 4) % 3);
            end
            {wt_busy, dma_busy, vpu_busy, sys_busy} = pick;
            left--;
            @(negedge clk);
            seen = dma_ctrl.start && dma_ctrl.dir;   // WR_HOST_MEM reached
            cycles++;
            if (cycles > 300) fail_run("Timed out waiting for WR_HOST_MEM to issue");
        end
        @(posedge clk);
        #5;
        {wt_busy, dma_busy, vpu_busy, sys_busy} = 4'b0;
    endtask

    task automatic wait_vpu(vpu_mode_e m);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) fail_run("Timed out waiting for an activation to issue");
        end while (!(vpu_ctrl.start && vpu_ctrl.mode == m));
    endtask

    task automatic wait_sys_start();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) fail_run("Timed out waiting for a matmul to issue");
        end while (!sys_ctrl.start);
    endtask

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 4) fail_run("Stall did not drop after the SYNC units went idle");
        end while (pipeline_stall);
    endtask

    task automatic wait_interrupt();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) fail_run("Timed out waiting for the HALT interrupt");
        end while (!interrupt_en);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [PC_W-1:0] halt_pc;
        int n;
        rst_n    = 1'b0;
        sys_busy = 1'b0;
        vpu_busy = 1'b0;
        dma_busy = 1'b0;
        wt_busy  = 1'b0;
        for (int a = 0; a < MEM_DEPTH; a++)
            imem[a] = {6'h20, 8'(a), ~8'(a), 8'(a) ^ 8'h5A, 2'b00};   // Decodes as NOP
        load_program();
        for (int i = 0; i < prog_len; i++) imem[i] = prog_word[i];

        repeat (15) @(posedge clk);
        @(negedge clk);
        check("reset bundle", CW'(bundle_now()), '0);
        check("reset status", CW'({halt_req, interrupt_en, pipeline_stall, instr_addr}), '0);
        @(posedge clk);
        #5;
        rst_n = 1'b1;

        random_busy_until_wr();
        wait_vpu(VPU_SIGMOID);

        // SYNC issues next cycle and busy rises once it waits
        @(posedge clk);
        #5;
        @(posedge clk);
        #5;
        sys_busy = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check("stall while SYNC waits on systolic", CW'(pipeline_stall), CW'(1));
        end
        @(posedge clk);
        #5;
        sys_busy = 1'b0;
        @(negedge clk);
        check("stall on the idle edge of SYNC", CW'(pipeline_stall), CW'(1));
        wait_stall_low();

        // Second SYNC times out while vector unit stays busy
        wait_sys_start();
        @(posedge clk);
        #5;
        @(posedge clk);
        #5;
        vpu_busy = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check("stall while vector unit busy", CW'(pipeline_stall), CW'(1));
        end
        @(posedge clk);
        #5;
        vpu_busy = 1'b0;
        @(negedge clk);
        check("stall after SYNC timeout", CW'(pipeline_stall), CW'(0));

        wait_interrupt();
        check("halt_req with interrupt", CW'(halt_req), CW'(1));
        halt_pc = instr_addr;
        repeat (20) begin
            @(negedge clk);
            check("interrupt pulse length", CW'(interrupt_en), CW'(0));
            check("halt_req held", CW'(halt_req), CW'(1));
            check("instr_addr frozen", CW'(instr_addr), CW'(halt_pc));
        end

        n = 0;
        for (int i = 0; i < prog_len; i++) begin
            if (prog_issues[i]) begin
                if (n >= seen_q.size()) fail_run($sformatf("Entry %0d never issued", i));
                check($sformatf("entry %0d bundle", i), seen_q[n],
                      with_parity(prog_exp[i], parity_at(i)));
                n++;
            end
        end
        check("issue count", CW'(seen_q.size()), CW'(n));

        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
hw/tpu_ctrl_pkg.sv
hw/tpu_fetch_decode.sv
hw/tpu_execute.sv
hw/tpu_sync_unit.sv
hw/tpu_cfg_regs.sv
hw/tpu_controller.sv
dv/tpu_controller_props.sv
dv/tb_tpu_controller.sv

// ==== Makefile ====
TOP := tb_tpu_controller

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
